//--- chimney_pkg.sv
////////////////////////////////////////
// Shared definitions of the chimney
// Widths, channel codes, flit header,
// per-channel payloads and flit type
////////////////////////////////////////

`default_nettype none

package chimney_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  localparam int unsigned TileIdWidth   = 4;
  localparam int unsigned AxiIdWidth    = 4;
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned LenWidth      = 8;
  localparam int unsigned RespWidth     = 2;

  // Destination tile sits in the top address bits
  localparam int unsigned DstAddrOffset = 28;

  // Sized for the widest channel (AW/AR)
  localparam int unsigned PayloadWidth  = 44;

  // Padding of the narrower payloads
  localparam int unsigned WPadWidth     = PayloadWidth - DataWidth - 1;
  localparam int unsigned BPadWidth     = PayloadWidth - AxiIdWidth - RespWidth;
  localparam int unsigned RPadWidth     = PayloadWidth - AxiIdWidth - DataWidth - RespWidth - 1;

  ////////////////////////////////////////
  // Basic types
  ////////////////////////////////////////

  typedef logic [TileIdWidth-1:0] tile_id_t;
  typedef logic [AxiIdWidth-1:0]  axi_id_t;
  typedef logic [AddrWidth-1:0]   addr_t;
  typedef logic [DataWidth-1:0]   data_t;
  typedef logic [LenWidth-1:0]    len_t;
  typedef logic [RespWidth-1:0]   resp_t;

  // Channel code carried in every header
  typedef enum logic [2:0] {
    ChAw = 3'd0,
    ChW  = 3'd1,
    ChAr = 3'd2,
    ChB  = 3'd3,
    ChR  = 3'd4
  } axi_ch_e;

  ////////////////////////////////////////
  // Flit layout
  ////////////////////////////////////////

  typedef struct packed {
    tile_id_t dst_id;
    tile_id_t src_id;
    axi_ch_e  axi_ch;
    logic     last;
  } flit_hdr_t;

  // AR uses the same layout
  typedef struct packed {
    axi_id_t id;
    addr_t   addr;
    len_t    len;
  } aw_payload_t;

  typedef struct packed {
    logic [WPadWidth-1:0] rsvd;
    data_t                data;
    logic                 last;
  } w_payload_t;

  typedef struct packed {
    logic [BPadWidth-1:0] rsvd;
    axi_id_t              id;
    resp_t                resp;
  } b_payload_t;

  typedef struct packed {
    logic [RPadWidth-1:0] rsvd;
    axi_id_t              id;
    data_t                data;
    resp_t                resp;
    logic                 last;
  } r_payload_t;

  // Header first with the payload in the low bits
  typedef struct packed {
    flit_hdr_t               hdr;
    logic [PayloadWidth-1:0] payload;
  } flit_t;

endpackage

`default_nettype wire

//--- arb_req_if.sv
////////////////////////////////////////
// Requester bundle between the packer
// and the wormhole arbiter
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

interface arb_req_if import chimney_pkg::*; ();

  // AW/W stream carrying one flit at a time
  logic  aw_w_valid;
  flit_t aw_w_flit;
  logic  aw_w_gnt;

  // AR stream
  logic  ar_valid;
  flit_t ar_flit;
  logic  ar_gnt;

  // Grant means transfer in this cycle
  modport packer (
    output aw_w_valid, aw_w_flit, ar_valid, ar_flit,
    input  aw_w_gnt, ar_gnt
  );

  modport arbiter (
    input  aw_w_valid, aw_w_flit, ar_valid, ar_flit,
    output aw_w_gnt, ar_gnt
  );

endinterface

`default_nettype wire

//--- req_packer.sv
////////////////////////////////////////
// Request packer
// AW, W and AR into request flits with
// AW/W stream selection
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module req_packer import chimney_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  tile_id_t id_i,
  // AW
  input  logic     aw_valid_i,
  input  axi_id_t  aw_id_i,
  input  addr_t    aw_addr_i,
  input  len_t     aw_len_i,
  output logic     aw_ready_o,
  // W
  input  logic     w_valid_i,
  input  data_t    w_data_i,
  input  logic     w_last_i,
  output logic     w_ready_o,
  // AR
  input  logic     ar_valid_i,
  input  axi_id_t  ar_id_i,
  input  addr_t    ar_addr_i,
  input  len_t     ar_len_i,
  output logic     ar_ready_o,
  // To the arbiter
  arb_req_if.packer arb
);

  typedef enum logic {SelAw, SelW} aw_w_sel_e;

  aw_w_sel_e aw_w_sel_q, aw_w_sel_d;
  tile_id_t  w_dst_q;
  flit_t     aw_flit, w_flit, ar_flit;
  logic      aw_hs, w_hs;

  ////////////////////////////////////////
  // Flit packing
  ////////////////////////////////////////

  always_comb begin
    aw_flit.hdr.dst_id = aw_addr_i[DstAddrOffset +: TileIdWidth];
    aw_flit.hdr.src_id = id_i;
    aw_flit.hdr.axi_ch = ChAw;
    // Burst still follows so the link stays held
    aw_flit.hdr.last   = 1'b0;
    aw_flit.payload    = aw_payload_t'{id: aw_id_i, addr: aw_addr_i, len: aw_len_i};
  end

  always_comb begin
    // Destination comes from the AW that opened the burst
    w_flit.hdr.dst_id = w_dst_q;
    w_flit.hdr.src_id = id_i;
    w_flit.hdr.axi_ch = ChW;
    w_flit.hdr.last   = w_last_i;
    w_flit.payload    = w_payload_t'{rsvd: '0, data: w_data_i, last: w_last_i};
  end

  always_comb begin
    ar_flit.hdr.dst_id = ar_addr_i[DstAddrOffset +: TileIdWidth];
    ar_flit.hdr.src_id = id_i;
    ar_flit.hdr.axi_ch = ChAr;
    ar_flit.hdr.last   = 1'b1;
    ar_flit.payload    = aw_payload_t'{id: ar_id_i, addr: ar_addr_i, len: ar_len_i};
  end

  ////////////////////////////////////////
  // AW/W selection
  ////////////////////////////////////////

  assign aw_hs = aw_valid_i && aw_ready_o;
  assign w_hs  = w_valid_i && w_ready_o;

  always_comb begin
    aw_w_sel_d = aw_w_sel_q;
    if (aw_hs) begin
      aw_w_sel_d = SelW;
    end else if (w_hs && w_last_i) begin
      aw_w_sel_d = SelAw;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      aw_w_sel_q <= SelAw;
    end else begin
      aw_w_sel_q <= aw_w_sel_d;
    end
  end

  // W destination captured with the AW
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      w_dst_q <= aw_flit.hdr.dst_id;
    end
  end

  // Requests and grants
  assign arb.aw_w_valid = (aw_w_sel_q == SelAw) ? aw_valid_i : w_valid_i;
  assign arb.aw_w_flit  = (aw_w_sel_q == SelAw) ? aw_flit : w_flit;
  assign arb.ar_valid   = ar_valid_i;
  assign arb.ar_flit    = ar_flit;

  assign aw_ready_o = arb.aw_w_gnt && (aw_w_sel_q == SelAw);
  assign w_ready_o  = arb.aw_w_gnt && (aw_w_sel_q == SelW);
  assign ar_ready_o = arb.ar_gnt;

  // The arbiter only grants a pending AR
  ar_gnt_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    arb.ar_gnt |-> arb.ar_valid);

endmodule

`default_nettype wire

//--- wormhole_arbiter.sv
////////////////////////////////////////
// Wormhole arbiter
// Round-robin over AW/W and AR with the
// grant held until a last flit is sent
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module wormhole_arbiter import chimney_pkg::*; (
  input  logic  clk_i,
  input  logic  rst_n_i,
  arb_req_if.arbiter arb,
  // Request link to the NoC
  output logic  req_valid_o,
  output flit_t req_flit_o,
  input  logic  req_ready_i
);

  typedef enum logic {SideAwW, SideAr} side_e;

  side_e rr_q;
  side_e lock_side_q;
  logic  lock_q;
  side_e sel;
  logic  xfer;

  ////////////////////////////////////////
  // Side selection
  ////////////////////////////////////////

  always_comb begin
    if (lock_q) begin
      // Open packet stays on its side
      sel = lock_side_q;
    end else if (arb.aw_w_valid && arb.ar_valid) begin
      sel = rr_q;
    end else if (arb.ar_valid) begin
      sel = SideAr;
    end else begin
      sel = SideAwW;
    end
  end

  assign req_valid_o = (sel == SideAr) ? arb.ar_valid : arb.aw_w_valid;
  assign req_flit_o  = (sel == SideAr) ? arb.ar_flit : arb.aw_w_flit;
  assign xfer        = req_valid_o && req_ready_i;

  assign arb.aw_w_gnt = xfer && (sel == SideAwW);
  assign arb.ar_gnt   = xfer && (sel == SideAr);

  ////////////////////////////////////////
  // Lock and priority
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lock_q      <= 1'b0;
      lock_side_q <= SideAwW;
      rr_q        <= SideAwW;
    end else if (xfer) begin
      if (req_flit_o.hdr.last) begin
        lock_q <= 1'b0;
        // Other side wins the next tie
        rr_q   <= (sel == SideAr) ? SideAwW : SideAr;
      end else begin
        lock_q      <= 1'b1;
        lock_side_q <= sel;
      end
    end
  end

  // Only an AW opens a packet, so a locked link carries its W beats
  locked_stays_on_w: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    lock_q && req_valid_o |->
      (lock_side_q == SideAwW) && (req_flit_o.hdr.axi_ch == ChW));

endmodule

`default_nettype wire

//--- rsp_unpacker.sv
////////////////////////////////////////
// Response unpacker
// Optional spill register, then flits
// split onto AXI B and R
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module rsp_unpacker import chimney_pkg::*; #(
  parameter bit CutRsp = 1'b1
) (
  input  logic    clk_i,
  input  logic    rst_n_i,
  // Response link from the NoC
  input  logic    rsp_valid_i,
  input  flit_t   rsp_flit_i,
  output logic    rsp_ready_o,
  // B
  output logic    b_valid_o,
  output axi_id_t b_id_o,
  output resp_t   b_resp_o,
  input  logic    b_ready_i,
  // R
  output logic    r_valid_o,
  output axi_id_t r_id_o,
  output data_t   r_data_o,
  output resp_t   r_resp_o,
  output logic    r_last_o,
  input  logic    r_ready_i
);

  flit_t      rsp_flit;
  logic       rsp_valid;
  logic       rsp_ready;
  b_payload_t b_pl;
  r_payload_t r_pl;

  ////////////////////////////////////////
  // Spill register
  ////////////////////////////////////////

  if (CutRsp) begin : gen_spill
    logic  a_full_q, b_full_q;
    flit_t a_data_q, b_data_q;
    logic  a_fill, a_drain, b_fill, b_drain;

    // Slot B holds the older flit when both are full
    assign rsp_ready_o = !a_full_q || !b_full_q;
    assign a_fill      = rsp_valid_i && rsp_ready_o;
    assign a_drain     = a_full_q && !b_full_q;
    assign b_fill      = a_drain && !rsp_ready;
    assign b_drain     = b_full_q && rsp_ready;

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        a_full_q <= 1'b0;
        b_full_q <= 1'b0;
      end else begin
        if (a_fill) begin
          a_full_q <= 1'b1;
        end else if (a_drain) begin
          a_full_q <= 1'b0;
        end
        if (b_fill) begin
          b_full_q <= 1'b1;
        end else if (b_drain) begin
          b_full_q <= 1'b0;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (a_fill) begin
        a_data_q <= rsp_flit_i;
      end
      if (b_fill) begin
        b_data_q <= a_data_q;
      end
    end

    assign rsp_valid = a_full_q || b_full_q;
    assign rsp_flit  = b_full_q ? b_data_q : a_data_q;
  end else begin : gen_no_spill
    assign rsp_valid   = rsp_valid_i;
    assign rsp_flit    = rsp_flit_i;
    assign rsp_ready_o = rsp_ready;
  end

  ////////////////////////////////////////
  // Channel demultiplexer
  ////////////////////////////////////////

  assign b_pl = b_payload_t'(rsp_flit.payload);
  assign r_pl = r_payload_t'(rsp_flit.payload);

  assign b_valid_o = rsp_valid && (rsp_flit.hdr.axi_ch == ChB);
  assign b_id_o    = b_pl.id;
  assign b_resp_o  = b_pl.resp;

  assign r_valid_o = rsp_valid && (rsp_flit.hdr.axi_ch == ChR);
  assign r_id_o    = r_pl.id;
  assign r_data_o  = r_pl.data;
  assign r_resp_o  = r_pl.resp;
  assign r_last_o  = r_pl.last;

  always_comb begin
    case (rsp_flit.hdr.axi_ch)
      ChB:     rsp_ready = b_ready_i;
      ChR:     rsp_ready = r_ready_i;
      // Sink stray codes so the link cannot stall
      default: rsp_ready = 1'b1;
    endcase
  end

  // Requests are never routed to this port
  no_req_on_rsp_link: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rsp_valid_i |-> rsp_flit_i.hdr.axi_ch inside {ChB, ChR});

endmodule

`default_nettype wire

//--- axi_chimney.sv
////////////////////////////////////////
// Manager-side AXI chimney top level
// Packer, wormhole arbiter, unpacker
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module axi_chimney import chimney_pkg::*; #(
  parameter bit CutRsp = 1'b1
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  tile_id_t id_i,
  // AW
  input  logic     aw_valid_i,
  input  axi_id_t  aw_id_i,
  input  addr_t    aw_addr_i,
  input  len_t     aw_len_i,
  output logic     aw_ready_o,
  // W
  input  logic     w_valid_i,
  input  data_t    w_data_i,
  input  logic     w_last_i,
  output logic     w_ready_o,
  // AR
  input  logic     ar_valid_i,
  input  axi_id_t  ar_id_i,
  input  addr_t    ar_addr_i,
  input  len_t     ar_len_i,
  output logic     ar_ready_o,
  // B
  output logic     b_valid_o,
  output axi_id_t  b_id_o,
  output resp_t    b_resp_o,
  input  logic     b_ready_i,
  // R
  output logic     r_valid_o,
  output axi_id_t  r_id_o,
  output data_t    r_data_o,
  output resp_t    r_resp_o,
  output logic     r_last_o,
  input  logic     r_ready_i,
  // Response link from the NoC
  input  logic     rsp_valid_i,
  input  flit_t    rsp_flit_i,
  output logic     rsp_ready_o,
  // Request link to the NoC
  output logic     req_valid_o,
  output flit_t    req_flit_o,
  input  logic     req_ready_i
);

  arb_req_if arb_if ();

  req_packer req_packer_inst (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .id_i       (id_i),
    .aw_valid_i (aw_valid_i),
    .aw_id_i    (aw_id_i),
    .aw_addr_i  (aw_addr_i),
    .aw_len_i   (aw_len_i),
    .aw_ready_o (aw_ready_o),
    .w_valid_i  (w_valid_i),
    .w_data_i   (w_data_i),
    .w_last_i   (w_last_i),
    .w_ready_o  (w_ready_o),
    .ar_valid_i (ar_valid_i),
    .ar_id_i    (ar_id_i),
    .ar_addr_i  (ar_addr_i),
    .ar_len_i   (ar_len_i),
    .ar_ready_o (ar_ready_o),
    .arb        (arb_if)
  );

  wormhole_arbiter wormhole_arbiter_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .arb         (arb_if),
    .req_valid_o (req_valid_o),
    .req_flit_o  (req_flit_o),
    .req_ready_i (req_ready_i)
  );

  rsp_unpacker #(
    .CutRsp (CutRsp)
  ) rsp_unpacker_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .rsp_valid_i (rsp_valid_i),
    .rsp_flit_i  (rsp_flit_i),
    .rsp_ready_o (rsp_ready_o),
    .b_valid_o   (b_valid_o),
    .b_id_o      (b_id_o),
    .b_resp_o    (b_resp_o),
    .b_ready_i   (b_ready_i),
    .r_valid_o   (r_valid_o),
    .r_id_o      (r_id_o),
    .r_data_o    (r_data_o),
    .r_resp_o    (r_resp_o),
    .r_last_o    (r_last_o),
    .r_ready_i   (r_ready_i)
  );

endmodule

`default_nettype wire

//--- tb_axi_chimney.sv
////////////////////////////////////////
// Testbench of the AXI chimney
// LFSR stimulus, model queues, compare
// tasks and a cycle timeout
////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_axi_chimney import chimney_pkg::*; ();

  localparam int          HalfPeriod    = 20;
  localparam int          DriveDelay    = 2;
  localparam int          ResetCycles   = 10;
  localparam int          NumWrites     = 30;
  localparam int          NumReads      = 30;
  localparam int          NumRsps       = 100;
  localparam int          CyclesPerBeat = 40;
  localparam tile_id_t    TileId        = 4'h5;
  localparam logic [15:0] LfsrSeed      = 16'd11736;
  // x^16 + x^14 + x^13 + x^11 + 1
  localparam logic [15:0] LfsrTaps      = 16'hB400;

  logic     clk_i, rst_n_i;
  tile_id_t id_i;
  logic     aw_valid_i, aw_ready_o, w_valid_i, w_last_i, w_ready_o;
  axi_id_t  aw_id_i, ar_id_i, b_id_o, r_id_o;
  addr_t    aw_addr_i, ar_addr_i;
  len_t     aw_len_i, ar_len_i;
  data_t    w_data_i, r_data_o;
  logic     ar_valid_i, ar_ready_o;
  logic     b_valid_o, b_ready_i, r_valid_o, r_last_o, r_ready_i;
  resp_t    b_resp_o, r_resp_o;
  logic     rsp_valid_i, rsp_ready_o, req_valid_o, req_ready_i;
  flit_t    rsp_flit_i, req_flit_o;

  // Stimulus still to send and expected results
  aw_payload_t aw_src_q[$], ar_src_q[$];
  w_payload_t  w_src_q[$];
  flit_t       rsp_src_q[$], exp_aw_w_q[$], exp_ar_q[$];
  b_payload_t  exp_b_q[$];
  r_payload_t  exp_r_q[$];

  logic [15:0] lfsr_q;
  logic        aw_hs, w_hs, ar_hs, rsp_hs;
  logic        burst_open, link_in_write;
  tile_id_t    burst_dst;
  int          errors, flits_checked, b_checked, r_checked;
  int          cycle_cnt = 0;
  int          timeout_limit;

  axi_chimney #(.CutRsp(1'b1)) axi_chimney_inst (.*);

  always #HalfPeriod clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > timeout_limit) begin
      $display("ERROR: timeout after %0d cycles with traffic still pending", cycle_cnt);
      $display("tests failed");
      $finish;
    end
  end

  // Galois LFSR whose shifted-out bit is the random bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = (lfsr_q >> 1) ^ (lfsr_q[0] ? LfsrTaps : 16'h0000);
    end
    return v;
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_flit(input string name, input flit_t act, input flit_t exp);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_b(input string name, input b_payload_t act, input b_payload_t exp);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_r(input string name, input r_payload_t act, input r_payload_t exp);
    if (act !== exp) begin
      $display("FAILED %s: expected %h, got %h", name, exp, act);
      errors++;
    end
  endtask

  ////////////////////////////////////////
  // Stimulus generation and driving
  ////////////////////////////////////////

  task automatic gen_stimulus();
    aw_payload_t ax;
    w_payload_t  w;
    b_payload_t  b;
    r_payload_t  r;
    flit_t       f;
    int          i, j, len_val;
    for (i = 0; i < NumWrites; i++) begin
      len_val = int'(rand_bits(2));
      ax.id   = axi_id_t'(rand_bits(AxiIdWidth));
      ax.addr = addr_t'(rand_bits(AddrWidth));
      ax.len  = len_t'(len_val);
      aw_src_q.push_back(ax);
      for (j = 0; j <= len_val; j++) begin
        w.rsvd = '0;
        w.data = data_t'(rand_bits(DataWidth));
        w.last = (j == len_val);
        w_src_q.push_back(w);
      end
    end
    for (i = 0; i < NumReads; i++) begin
      ax.id   = axi_id_t'(rand_bits(AxiIdWidth));
      ax.addr = addr_t'(rand_bits(AddrWidth));
      ax.len  = len_t'(rand_bits(2));
      ar_src_q.push_back(ax);
    end
    for (i = 0; i < NumRsps; i++) begin
      f.hdr.dst_id = TileId;
      f.hdr.src_id = tile_id_t'(rand_bits(TileIdWidth));
      f.hdr.last   = 1'b1;
      if (rand_bits(1) == 1) begin
        f.hdr.axi_ch = ChR;
        r.rsvd       = '0;
        r.id         = axi_id_t'(rand_bits(AxiIdWidth));
        r.data       = data_t'(rand_bits(DataWidth));
        r.resp       = resp_t'(rand_bits(RespWidth));
        r.last       = (rand_bits(1) == 1);
        f.payload    = r;
      end else begin
        f.hdr.axi_ch = ChB;
        b.rsvd       = '0;
        b.id         = axi_id_t'(rand_bits(AxiIdWidth));
        b.resp       = resp_t'(rand_bits(RespWidth));
        f.payload    = b;
      end
      rsp_src_q.push_back(f);
    end
    timeout_limit = CyclesPerBeat *
      (aw_src_q.size() + w_src_q.size() + ar_src_q.size() + rsp_src_q.size());
  endtask

  task automatic drive_inputs();
    // Retire what was taken at the last edge
    if (aw_hs) begin
      void'(aw_src_q.pop_front());
      aw_valid_i = 1'b0;
    end
    if (w_hs) begin
      void'(w_src_q.pop_front());
      w_valid_i = 1'b0;
    end
    if (ar_hs) begin
      void'(ar_src_q.pop_front());
      ar_valid_i = 1'b0;
    end
    if (rsp_hs) begin
      void'(rsp_src_q.pop_front());
      rsp_valid_i = 1'b0;
    end
    // A raised valid holds until its handshake
    if (!aw_valid_i && aw_src_q.size() > 0 && rand_bits(1) == 1) begin
      aw_valid_i = 1'b1;
      aw_id_i    = aw_src_q[0].id;
      aw_addr_i  = aw_src_q[0].addr;
      aw_len_i   = aw_src_q[0].len;
    end
    if (!w_valid_i && w_src_q.size() > 0 && rand_bits(1) == 1) begin
      w_valid_i = 1'b1;
      w_data_i  = w_src_q[0].data;
      w_last_i  = w_src_q[0].last;
    end
    if (!ar_valid_i && ar_src_q.size() > 0 && rand_bits(1) == 1) begin
      ar_valid_i = 1'b1;
      ar_id_i    = ar_src_q[0].id;
      ar_addr_i  = ar_src_q[0].addr;
      ar_len_i   = ar_src_q[0].len;
    end
    if (!rsp_valid_i && rsp_src_q.size() > 0 && rand_bits(1) == 1) begin
      rsp_valid_i = 1'b1;
      rsp_flit_i  = rsp_src_q[0];
    end
    req_ready_i = (rand_bits(2) != 0);
    b_ready_i   = (rand_bits(2) != 0);
    r_ready_i   = (rand_bits(2) != 0);
  endtask

  ////////////////////////////////////////
  // Model and checks
  ////////////////////////////////////////

  task automatic sample_outputs();
    flit_t      exp;
    b_payload_t b_exp;
    r_payload_t r_exp;
    aw_hs  = aw_valid_i && aw_ready_o;
    w_hs   = w_valid_i && w_ready_o;
    ar_hs  = ar_valid_i && ar_ready_o;
    rsp_hs = rsp_valid_i && rsp_ready_o;
    if (!req_ready_i && (aw_ready_o || w_ready_o || ar_ready_o)) begin
      $display("ERROR: AXI request accepted while req_ready_i is low");
      errors++;
    end
    if (aw_hs) begin
      exp.hdr     = '{dst_id: aw_addr_i[31:28], src_id: TileId, axi_ch: ChAw, last: 1'b0};
      exp.payload = {aw_id_i, aw_addr_i, aw_len_i};
      exp_aw_w_q.push_back(exp);
      burst_dst  = aw_addr_i[31:28];
      burst_open = 1'b1;
    end
    if (w_hs) begin
      if (!burst_open) begin
        $display("ERROR: W beat accepted before its AW");
        errors++;
      end
      exp.hdr     = '{dst_id: burst_dst, src_id: TileId, axi_ch: ChW, last: w_last_i};
      exp.payload = {{(PayloadWidth - DataWidth - 1){1'b0}}, w_data_i, w_last_i};
      exp_aw_w_q.push_back(exp);
      if (w_last_i) begin
        burst_open = 1'b0;
      end
    end
    if (ar_hs) begin
      exp.hdr     = '{dst_id: ar_addr_i[31:28], src_id: TileId, axi_ch: ChAr, last: 1'b1};
      exp.payload = {ar_id_i, ar_addr_i, ar_len_i};
      exp_ar_q.push_back(exp);
    end
    // Flit leaving on the request link
    if (req_valid_o && req_ready_i) begin
      if (req_flit_o.hdr.axi_ch == ChAr) begin
        if (link_in_write) begin
          $display("ERROR: AR flit sent inside an open write burst");
          errors++;
        end
        if (exp_ar_q.size() == 0) begin
          $display("ERROR: AR flit sent with no accepted AR request");
          errors++;
        end else begin
          exp = exp_ar_q.pop_front();
          check_flit("req_flit_o", req_flit_o, exp);
        end
      end else if (exp_aw_w_q.size() == 0) begin
        $display("ERROR: AW or W flit sent with no accepted request");
        errors++;
      end else begin
        exp = exp_aw_w_q.pop_front();
        check_flit("req_flit_o", req_flit_o, exp);
        link_in_write = !exp.hdr.last;
      end
      flits_checked++;
    end
    if (b_valid_o && b_ready_i) begin
      if (exp_b_q.size() == 0) begin
        $display("ERROR: B beat with no accepted response flit");
        errors++;
      end else begin
        b_exp = exp_b_q.pop_front();
        check_b("b_id_o/b_resp_o", b_payload_t'{rsvd: '0, id: b_id_o, resp: b_resp_o}, b_exp);
      end
      b_checked++;
    end
    if (r_valid_o && r_ready_i) begin
      if (exp_r_q.size() == 0) begin
        $display("ERROR: R beat with no accepted response flit");
        errors++;
      end else begin
        r_exp = exp_r_q.pop_front();
        check_r("r_id_o/r_data_o/r_resp_o/r_last_o", r_payload_t'{rsvd: '0, id: r_id_o,
          data: r_data_o, resp: r_resp_o, last: r_last_o}, r_exp);
      end
      r_checked++;
    end
    // A response flit taken now may leave from the next cycle on
    if (rsp_hs) begin
      if (rsp_flit_i.hdr.axi_ch == ChB) begin
        exp_b_q.push_back(b_payload_t'(rsp_flit_i.payload));
      end else begin
        exp_r_q.push_back(r_payload_t'(rsp_flit_i.payload));
      end
    end
  endtask

  function automatic bit all_done();
    return aw_src_q.size() == 0 && w_src_q.size() == 0 && ar_src_q.size() == 0 &&
      rsp_src_q.size() == 0 && exp_aw_w_q.size() == 0 && exp_ar_q.size() == 0 &&
      exp_b_q.size() == 0 && exp_r_q.size() == 0;
  endfunction

  initial begin
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    id_i        = TileId;
    aw_valid_i  = 1'b0;
    aw_id_i     = '0;
    aw_addr_i   = '0;
    aw_len_i    = '0;
    w_valid_i   = 1'b0;
    w_data_i    = '0;
    w_last_i    = 1'b0;
    ar_valid_i  = 1'b0;
    ar_id_i     = '0;
    ar_addr_i   = '0;
    ar_len_i    = '0;
    b_ready_i   = 1'b0;
    r_ready_i   = 1'b0;
    rsp_valid_i = 1'b0;
    rsp_flit_i  = '0;
    req_ready_i = 1'b0;
    lfsr_q      = LfsrSeed;
    {aw_hs, w_hs, ar_hs, rsp_hs} = '0;
    burst_open    = 1'b0;
    link_in_write = 1'b0;
    burst_dst     = '0;
    errors        = 0;
    flits_checked = 0;
    b_checked     = 0;
    r_checked     = 0;
    gen_stimulus();
    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_n_i = 1'b1;
    @(negedge clk_i);
    if (b_valid_o !== 1'b0 || r_valid_o !== 1'b0) begin
      $display("ERROR: B or R valid is not low right after reset");
      errors++;
    end
    while (!all_done()) begin
      @(posedge clk_i);
      #DriveDelay;
      drive_inputs();
      @(negedge clk_i);
      sample_outputs();
    end
    $display("Request flits %0d, B beats %0d, R beats %0d, errors %0d",
      flits_checked, b_checked, r_checked, errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- axi_chimney.f
chimney_pkg.sv
arb_req_if.sv
req_packer.sv
wormhole_arbiter.sv
rsp_unpacker.sv
axi_chimney.sv
tb_axi_chimney.sv

//--- Makefile
# Verilator simulation of the AXI chimney

.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f axi_chimney.f --top-module tb_axi_chimney -o sim_axi_chimney
	./obj_dir/sim_axi_chimney | tee sim.log
	grep -q "all tests passed" sim.log

lint:
	verilator --lint-only --timing -f axi_chimney.f --top-module tb_axi_chimney
	verilator --lint-only chimney_pkg.sv arb_req_if.sv req_packer.sv wormhole_arbiter.sv rsp_unpacker.sv axi_chimney.sv --top-module axi_chimney

clean:
	rm -rf obj_dir sim.log
